// ==== csr_file.sv ====
// machine-mode CSR file: mstatus, mtvec, mepc, mcause
`timescale 1ns/1ps
`default_nettype none

module csr_file import exe_pkg::*; (
  input  wire             clk,
  input  wire             rst,
  input  wire csr_req_t   i_csr,
  output logic [xlen-1:0] o_rdata,
  output logic            o_mie
);

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (i_csr.wen) begin
      case (i_csr.addr)
        csr_mstatus: mstatus <= i_csr.wdata;
        csr_mtvec:   mtvec   <= i_csr.wdata;
        csr_mepc:    mepc    <= i_csr.wdata;
        csr_mcause:  mcause  <= i_csr.wdata;
        // unmapped addresses drop the write
        default: begin
          mstatus <= mstatus;
        end
      endcase
    end
  end

  // same-cycle read
  always_comb begin
    o_rdata = '0;
    if (i_csr.ren) begin
      case (i_csr.addr)
        csr_mstatus: o_rdata = mstatus;
        csr_mtvec:   o_rdata = mtvec;
        csr_mepc:    o_rdata = mepc;
        csr_mcause:  o_rdata = mcause;
        default:     o_rdata = '0;
      endcase
    end
  end

  assign o_mie = mstatus[mstatus_mie_bit];

endmodule

`default_nettype wire

// ==== exception_unit.sv ====
// multi-cycle exception unit
// trap entry and mret sequences over the CSR port
`timescale 1ns/1ps
`default_nettype none

module exception_unit import exe_pkg::*; (
  input  wire             clk,
  input  wire             rst,
  input  wire             i_start,
  input  wire             i_is_mret,
  input  wire             i_is_intr,
  input  wire [xlen-1:0]  i_pc,
  input  wire [xlen-1:0]  i_csr_rdata,
  output csr_req_t        o_csr,
  output logic            o_done,
  output logic [xlen-1:0] o_jmp_addr
);

  exc_state_e      state;
  exc_state_e      state_nxt;
  logic [xlen-1:0] target_q;
  logic [xlen-1:0] cause;
  logic [xlen-1:0] status_trap;
  logic [xlen-1:0] status_mret;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= exc_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // jump target, mtvec on trap entry or mepc on mret
  always_ff @(posedge clk) begin
    if (state == exc_rd_vec) begin
      target_q <= i_csr_rdata;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      exc_idle: begin
        if (i_start) begin
          state_nxt = exc_rd_vec;
        end
      end
      exc_rd_vec:    state_nxt = i_is_mret ? exc_wr_status : exc_wr_epc;
      exc_wr_epc:    state_nxt = exc_wr_cause;
      exc_wr_cause:  state_nxt = exc_wr_status;
      exc_wr_status: state_nxt = exc_done;
      exc_done:      state_nxt = exc_idle;
      default:       state_nxt = exc_idle;
    endcase
  end

  // interrupt causes carry the top bit; 11 is ecall from m-mode
  assign cause = i_is_intr ? {1'b1, {(xlen-9){1'b0}}, timer_intr_no} : xlen'(11);

  always_comb begin
    status_trap                   = i_csr_rdata;
    status_trap[mstatus_mpie_bit] = i_csr_rdata[mstatus_mie_bit];
    status_trap[mstatus_mie_bit]  = 1'b0;
    status_mret                   = i_csr_rdata;
    status_mret[mstatus_mie_bit]  = i_csr_rdata[mstatus_mpie_bit];
    status_mret[mstatus_mpie_bit] = 1'b1;
  end

  always_comb begin
    o_csr = '0;
    case (state)
      exc_rd_vec: begin
        o_csr.addr = i_is_mret ? csr_mepc : csr_mtvec;
        o_csr.ren  = 1'b1;
      end
      exc_wr_epc: begin
        o_csr.addr  = csr_mepc;
        o_csr.wen   = 1'b1;
        o_csr.wdata = i_pc;
      end
      exc_wr_cause: begin
        o_csr.addr  = csr_mcause;
        o_csr.wen   = 1'b1;
        o_csr.wdata = cause;
      end
      // read-modify-write of mstatus in one cycle
      exc_wr_status: begin
        o_csr.addr  = csr_mstatus;
        o_csr.ren   = 1'b1;
        o_csr.wen   = 1'b1;
        o_csr.wdata = i_is_mret ? status_mret : status_trap;
      end
      default: o_csr = '0;
    endcase
  end

  // last write ends the sequence
  assign o_done     = (state == exc_wr_status);
  assign o_jmp_addr = target_q;

endmodule

`default_nettype wire

// ==== exe_pkg.sv ====
// widths, CSR map, opcode and exception FSM enums
// decoded instruction, result record and CSR request structs
`default_nettype none

package exe_pkg;

  localparam int xlen       = 64;
  localparam int ridx_w     = 5;
  localparam int csr_addr_w = 12;

  // machine-mode CSR addresses
  localparam logic [csr_addr_w-1:0] csr_mstatus = 12'h300;
  localparam logic [csr_addr_w-1:0] csr_mtvec   = 12'h305;
  localparam logic [csr_addr_w-1:0] csr_mepc    = 12'h341;
  localparam logic [csr_addr_w-1:0] csr_mcause  = 12'h342;

  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;

  localparam logic [7:0] timer_intr_no = 8'd7;

  typedef enum logic [4:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_slt,
    op_beq,
    op_bne,
    op_jal,
    op_jalr,
    op_csrrw,
    op_csrrs,
    op_ecall,
    op_mret
  } exe_op_e;

  typedef enum logic [2:0] {
    exc_idle,
    exc_rd_vec,
    exc_wr_epc,
    exc_wr_cause,
    exc_wr_status,
    exc_done
  } exc_state_e;

  typedef struct packed {
    exe_op_e           op;
    logic [xlen-1:0]   pc;
    logic [xlen-1:0]   op1;
    logic [xlen-1:0]   op2;
    // immediate or CSR address
    logic [xlen-1:0]   op3;
    logic [ridx_w-1:0] rd;
    logic              rd_wen;
  } exe_req_t;

  typedef struct packed {
    logic [xlen-1:0]   pc;
    logic [ridx_w-1:0] rd;
    logic              rd_wen;
    logic [xlen-1:0]   rd_wdata;
    logic              pc_jmp;
    logic [xlen-1:0]   jmp_addr;
    logic [7:0]        intr_no;
  } exe_result_t;

  typedef struct packed {
    logic [csr_addr_w-1:0] addr;
    logic                  ren;
    logic                  wen;
    logic [xlen-1:0]       wdata;
  } csr_req_t;

endpackage

`default_nettype wire

// ==== exe_stage.sv ====
// execute stage control: accept, path select, CSR mux
// and the held result record on the executed handshake
`timescale 1ns/1ps
`default_nettype none

module exe_stage import exe_pkg::*; (
  input  wire             clk,
  input  wire             rst,
  input  wire             i_dec_req,
  input  wire exe_req_t   i_dec_instr,
  output logic            o_dec_ack,
  input  wire             i_mtie,
  input  wire             i_mtime_overflow,
  input  wire             i_mie,
  input  wire [xlen-1:0]  i_csr_rdata,
  output csr_req_t        o_csr,
  output logic            o_exe_req,
  output exe_result_t     o_exe_result,
  input  wire             i_exe_ack
);

  exe_req_t        instr_q;
  logic            busy;
  logic            use_exc;
  logic            intr_q;
  logic            exu_first;
  logic [xlen-1:0] rd_wdata_q;
  logic            dec_hs;
  logic            exe_hs;
  logic            intr_pend;
  logic            to_exc;
  logic            exc_is_mret;
  csr_req_t        exu_csr;
  csr_req_t        exc_csr;
  logic [xlen-1:0] exu_rd_wdata;
  logic [xlen-1:0] exu_jmp_addr;
  logic [xlen-1:0] exc_jmp_addr;
  logic            exu_pc_jmp;
  logic            exc_done;

  assign o_dec_ack = !busy;
  assign dec_hs    = i_dec_req & o_dec_ack;
  assign exe_hs    = o_exe_req & i_exe_ack;
  assign intr_pend = i_mtime_overflow & i_mtie & i_mie;
  // pending timer interrupt wins and the instruction is dropped
  assign to_exc    = intr_pend | (i_dec_instr.op == op_ecall) | (i_dec_instr.op == op_mret);
  assign exc_is_mret = (instr_q.op == op_mret) && !intr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      use_exc   <= 1'b0;
      intr_q    <= 1'b0;
      exu_first <= 1'b0;
      o_exe_req <= 1'b0;
    end else begin
      exu_first <= dec_hs & !to_exc;
      if (dec_hs) begin
        busy      <= 1'b1;
        use_exc   <= to_exc;
        intr_q    <= intr_pend;
        o_exe_req <= !to_exc;
      end else if (exe_hs) begin
        busy      <= 1'b0;
        use_exc   <= 1'b0;
        o_exe_req <= 1'b0;
      end else if (exc_done) begin
        o_exe_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dec_hs) begin
      instr_q <= i_dec_instr;
    end
    // CSR old value changes after the write edge
    if (exu_first) begin
      rd_wdata_q <= exu_rd_wdata;
    end
  end

  always_comb begin
    if (exu_first) begin
      o_csr = exu_csr;
    end else if (use_exc) begin
      o_csr = exc_csr;
    end else begin
      o_csr = '0;
    end
  end

  always_comb begin
    o_exe_result.pc      = instr_q.pc;
    o_exe_result.rd      = instr_q.rd;
    o_exe_result.intr_no = intr_q ? timer_intr_no : 8'd0;
    if (use_exc) begin
      o_exe_result.rd_wen   = 1'b0;
      o_exe_result.rd_wdata = '0;
      o_exe_result.pc_jmp   = 1'b1;
      o_exe_result.jmp_addr = exc_jmp_addr;
    end else begin
      o_exe_result.rd_wen   = instr_q.rd_wen;
      o_exe_result.rd_wdata = exu_first ? exu_rd_wdata : rd_wdata_q;
      o_exe_result.pc_jmp   = exu_pc_jmp;
      o_exe_result.jmp_addr = exu_jmp_addr;
    end
  end

  exe_unit i_exe_unit (
    .i_instr     (instr_q),
    .i_csr_rdata (i_csr_rdata),
    .o_csr       (exu_csr),
    .o_rd_wdata  (exu_rd_wdata),
    .o_pc_jmp    (exu_pc_jmp),
    .o_jmp_addr  (exu_jmp_addr)
  );

  exception_unit i_exception_unit (
    .clk         (clk),
    .rst         (rst),
    .i_start     (dec_hs & to_exc),
    .i_is_mret   (exc_is_mret),
    .i_is_intr   (intr_q),
    .i_pc        (instr_q.pc),
    .i_csr_rdata (i_csr_rdata),
    .o_csr       (exc_csr),
    .o_done      (exc_done),
    .o_jmp_addr  (exc_jmp_addr)
  );

endmodule

`default_nettype wire

// ==== exe_top.sv ====
// execute stage top level with the machine-mode CSR file
`timescale 1ns/1ps
`default_nettype none

module exe_top import exe_pkg::*; (
  input  wire          clk,
  input  wire          rst,
  input  wire          i_dec_req,
  input  wire exe_req_t i_dec_instr,
  output logic         o_dec_ack,
  input  wire          i_mtie,
  input  wire          i_mtime_overflow,
  output logic         o_exe_req,
  output exe_result_t  o_exe_result,
  input  wire          i_exe_ack
);

  csr_req_t        csr_req;
  logic [xlen-1:0] csr_rdata;
  logic            mie;

  exe_stage i_exe_stage (
    .clk              (clk),
    .rst              (rst),
    .i_dec_req        (i_dec_req),
    .i_dec_instr      (i_dec_instr),
    .o_dec_ack        (o_dec_ack),
    .i_mtie           (i_mtie),
    .i_mtime_overflow (i_mtime_overflow),
    .i_mie            (mie),
    .i_csr_rdata      (csr_rdata),
    .o_csr            (csr_req),
    .o_exe_req        (o_exe_req),
    .o_exe_result     (o_exe_result),
    .i_exe_ack        (i_exe_ack)
  );

  csr_file i_csr_file (
    .clk     (clk),
    .rst     (rst),
    .i_csr   (csr_req),
    .o_rdata (csr_rdata),
    .o_mie   (mie)
  );

endmodule

`default_nettype wire

// ==== exe_unit.sv ====
// single-cycle execute unit
// ALU, branch and jump target, CSR read-modify-write request
`timescale 1ns/1ps
`default_nettype none

module exe_unit import exe_pkg::*; (
  input  wire exe_req_t   i_instr,
  input  wire [xlen-1:0]  i_csr_rdata,
  output csr_req_t        o_csr,
  output logic [xlen-1:0] o_rd_wdata,
  output logic            o_pc_jmp,
  output logic [xlen-1:0] o_jmp_addr
);

  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] br_target;
  logic [xlen-1:0] link_addr;
  logic [5:0]      shamt;
  logic            is_csr;
  logic            slt_res;

  assign shamt     = i_instr.op2[5:0];
  assign br_target = i_instr.pc + i_instr.op3;
  assign link_addr = i_instr.pc + xlen'(4);
  assign is_csr    = (i_instr.op == op_csrrw) || (i_instr.op == op_csrrs);
  assign slt_res   = $signed(i_instr.op1) < $signed(i_instr.op2);

  always_comb begin
    case (i_instr.op)
      op_add:  alu_res = i_instr.op1 + i_instr.op2;
      op_sub:  alu_res = i_instr.op1 - i_instr.op2;
      op_and:  alu_res = i_instr.op1 & i_instr.op2;
      op_or:   alu_res = i_instr.op1 | i_instr.op2;
      op_xor:  alu_res = i_instr.op1 ^ i_instr.op2;
      op_sll:  alu_res = i_instr.op1 << shamt;
      op_srl:  alu_res = i_instr.op1 >> shamt;
      op_slt:  alu_res = {{(xlen-1){1'b0}}, slt_res};
      default: alu_res = '0;
    endcase
  end

  // write-back value
  always_comb begin
    case (i_instr.op)
      op_jal,
      op_jalr:  o_rd_wdata = link_addr;
      op_csrrw,
      op_csrrs: o_rd_wdata = i_csr_rdata;
      default:  o_rd_wdata = alu_res;
    endcase
  end

  // jump decision, target is kept even when a branch falls through
  always_comb begin
    o_pc_jmp   = 1'b0;
    o_jmp_addr = '0;
    case (i_instr.op)
      op_beq: begin
        o_pc_jmp   = (i_instr.op1 == i_instr.op2);
        o_jmp_addr = br_target;
      end
      op_bne: begin
        o_pc_jmp   = (i_instr.op1 != i_instr.op2);
        o_jmp_addr = br_target;
      end
      op_jal: begin
        o_pc_jmp   = 1'b1;
        o_jmp_addr = br_target;
      end
      op_jalr: begin
        o_pc_jmp   = 1'b1;
        o_jmp_addr = (i_instr.op1 + i_instr.op3) & ~xlen'(1);
      end
      default: begin
        o_pc_jmp   = 1'b0;
        o_jmp_addr = '0;
      end
    endcase
  end

  // csrrs sets bits on top of the old value
  always_comb begin
    o_csr.addr  = i_instr.op3[csr_addr_w-1:0];
    o_csr.ren   = is_csr;
    o_csr.wen   = is_csr;
    o_csr.wdata = (i_instr.op == op_csrrs) ? (i_csr_rdata | i_instr.op1) : i_instr.op1;
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing -f verilog.f --top-module tb_exe_top -o tb_exe_top > build.log 2>&1 &&
./obj_dir/tb_exe_top > sim.log 2>&1 || { cat build.log sim.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb_exe_top.sv ====
// directed testbench for the execute stage top level
// reference model of the stage rules, compare tasks, one task per test
`timescale 1ns/1ps
`default_nettype none

module tb_exe_top import exe_pkg::*; ();

  logic            clk = 1'b0;
  logic            rst;
  logic            i_dec_req;
  exe_req_t        i_dec_instr;
  logic            o_dec_ack;
  logic            i_mtie;
  logic            i_mtime_overflow;
  logic            o_exe_req;
  exe_result_t     o_exe_result;
  logic            i_exe_ack;
  integer          seed;
  int              n_errors;
  int              n_checks;
  logic [xlen-1:0] trap_vec;

  always #10 clk = ~clk;

  exe_top i_exe_top (
    .clk              (clk),
    .rst              (rst),
    .i_dec_req        (i_dec_req),
    .i_dec_instr      (i_dec_instr),
    .o_dec_ack        (o_dec_ack),
    .i_mtie           (i_mtie),
    .i_mtime_overflow (i_mtime_overflow),
    .o_exe_req        (o_exe_req),
    .o_exe_result     (o_exe_result),
    .i_exe_ack        (i_exe_ack)
  );

  function automatic logic [xlen-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic exe_req_t make_instr(input exe_op_e op, input logic [xlen-1:0] pc,
      input logic [xlen-1:0] op1, input logic [xlen-1:0] op2, input logic [xlen-1:0] op3,
      input logic [ridx_w-1:0] rd, input logic rd_wen);
    exe_req_t r;
    r.op     = op;
    r.pc     = pc;
    r.op1    = op1;
    r.op2    = op2;
    r.op3    = op3;
    r.rd     = rd;
    r.rd_wen = rd_wen;
    return r;
  endfunction

  // expected record for the single-cycle path, csr_old is the CSR value before the write
  function automatic exe_result_t model_exe(input exe_req_t r, input logic [xlen-1:0] csr_old);
    exe_result_t e;
    e        = '0;
    e.pc     = r.pc;
    e.rd     = r.rd;
    e.rd_wen = r.rd_wen;
    case (r.op)
      op_add: e.rd_wdata = r.op1 + r.op2;
      op_sub: e.rd_wdata = r.op1 - r.op2;
      op_and: e.rd_wdata = r.op1 & r.op2;
      op_or:  e.rd_wdata = r.op1 | r.op2;
      op_xor: e.rd_wdata = r.op1 ^ r.op2;
      op_sll: e.rd_wdata = r.op1 << r.op2[5:0];
      op_srl: e.rd_wdata = r.op1 >> r.op2[5:0];
      op_slt: e.rd_wdata = ($signed(r.op1) < $signed(r.op2)) ? 64'd1 : 64'd0;
      op_beq, op_bne: begin
        e.pc_jmp   = (r.op == op_beq) ? (r.op1 == r.op2) : (r.op1 != r.op2);
        e.jmp_addr = r.pc + r.op3;
      end
      op_jal: begin
        e.rd_wdata = r.pc + 64'd4;
        e.pc_jmp   = 1'b1;
        e.jmp_addr = r.pc + r.op3;
      end
      op_jalr: begin
        e.rd_wdata = r.pc + 64'd4;
        e.pc_jmp   = 1'b1;
        e.jmp_addr = (r.op1 + r.op3) & ~64'd1;
      end
      op_csrrw, op_csrrs: e.rd_wdata = csr_old;
      default: e.rd_wdata = '0;
    endcase
    return e;
  endfunction

  // trap entry, interrupt or mret: no write-back, always a jump
  function automatic exe_result_t model_trap(input exe_req_t r, input logic [xlen-1:0] target,
      input logic intr);
    exe_result_t e;
    e          = '0;
    e.pc       = r.pc;
    e.rd       = r.rd;
    e.pc_jmp   = 1'b1;
    e.jmp_addr = target;
    e.intr_no  = intr ? 8'd7 : 8'd0;
    return e;
  endfunction

  task automatic finish_run();
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  task automatic check_result(input string name, input exe_result_t exp, input exe_result_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_xlen(input string name, input logic [xlen-1:0] exp,
      input logic [xlen-1:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // called on a falling edge, returns on the falling edge after the accept
  task automatic send_instr(input string name, input exe_req_t r);
    int n;
    n = 0;
    while (!o_dec_ack && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!o_dec_ack) begin
      n_errors++;
      $display("%s: stage never became ready for a new instruction", name);
      finish_run();
    end else begin
      i_dec_req   = 1'b1;
      i_dec_instr = r;
      @(posedge clk);
      @(negedge clk);
      i_dec_req = 1'b0;
    end
  endtask

  task automatic wait_exe_req(input string name);
    int n;
    n = 0;
    while (!o_exe_req && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!o_exe_req) begin
      n_errors++;
      $display("%s: no result came out of the stage", name);
      finish_run();
    end
  endtask

  task automatic get_result(input string name, output exe_result_t act);
    wait_exe_req(name);
    act       = o_exe_result;
    i_exe_ack = 1'b1;
    @(posedge clk);
    @(negedge clk);
    i_exe_ack = 1'b0;
  endtask

  task automatic run_exe(input string name, input exe_req_t r, input logic [xlen-1:0] csr_old);
    exe_result_t act;
    send_instr(name, r);
    get_result(name, act);
    check_result(name, model_exe(r, csr_old), act);
  endtask

  // csrrs with a zero mask reads without changing the register
  task automatic check_csr(input string name, input logic [csr_addr_w-1:0] addr,
      input logic [xlen-1:0] exp);
    exe_result_t act;
    send_instr(name, make_instr(op_csrrs, 64'h100, '0, '0, xlen'(addr), 5'd1, 1'b1));
    get_result(name, act);
    check_xlen(name, exp, act.rd_wdata);
  endtask

  task automatic test_alu();
    exe_op_e ops [8];
    int      k;
    int      j;
    ops = '{op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_slt};
    for (k = 0; k < 8; k++) begin
      for (j = 0; j < 4; j++) begin
        run_exe($sformatf("alu %s", ops[k].name()),
                make_instr(ops[k], rand64(), rand64(), rand64(), '0,
                           ridx_w'($random(seed)), 1'b1), '0);
      end
    end
  endtask

  task automatic test_branch_jump();
    logic [xlen-1:0] a;
    logic [xlen-1:0] pc;
    a  = rand64();
    pc = 64'h8000_0040;
    run_exe("beq taken", make_instr(op_beq, pc, a, a, 64'h20, '0, 1'b0), '0);
    run_exe("beq not taken", make_instr(op_beq, pc, a, a ^ 64'h10, 64'h20, '0, 1'b0), '0);
    run_exe("bne taken", make_instr(op_bne, pc, a, a ^ 64'h10, 64'h30, '0, 1'b0), '0);
    run_exe("bne not taken", make_instr(op_bne, pc, a, a, 64'h30, '0, 1'b0), '0);
    run_exe("jal", make_instr(op_jal, pc, '0, '0, 64'hffff_ffff_ffff_fff0, 5'd1, 1'b1), '0);
    run_exe("jalr", make_instr(op_jalr, pc, a | 64'd1, '0, 64'h6, 5'd1, 1'b1), '0);
  endtask

  task automatic test_csr();
    logic [xlen-1:0] a;
    a = rand64();
    run_exe("csrrw mtvec first",
            make_instr(op_csrrw, 64'h200, a, '0, xlen'(csr_mtvec), 5'd2, 1'b1), '0);
    run_exe("csrrs mtvec read",
            make_instr(op_csrrs, 64'h204, '0, '0, xlen'(csr_mtvec), 5'd2, 1'b1), a);
    run_exe("csrrw mtvec second",
            make_instr(op_csrrw, 64'h208, trap_vec, '0, xlen'(csr_mtvec), 5'd2, 1'b1), a);
    check_csr("mtvec readback", csr_mtvec, trap_vec);
  endtask

  task automatic test_ecall_mret();
    exe_req_t    r;
    exe_result_t act;
    run_exe("set mstatus mie",
            make_instr(op_csrrw, 64'h300, 64'h8, '0, xlen'(csr_mstatus), 5'd3, 1'b1), '0);
    r = make_instr(op_ecall, 64'h8000_0200, '0, '0, '0, '0, 1'b0);
    send_instr("ecall", r);
    get_result("ecall", act);
    check_result("ecall", model_trap(r, trap_vec, 1'b0), act);
    check_csr("mepc after ecall", csr_mepc, 64'h8000_0200);
    check_csr("mcause after ecall", csr_mcause, 64'd11);
    check_csr("mstatus after ecall", csr_mstatus, 64'h80);
    r = make_instr(op_mret, 64'h8000_0104, '0, '0, '0, '0, 1'b0);
    send_instr("mret", r);
    get_result("mret", act);
    check_result("mret", model_trap(r, 64'h8000_0200, 1'b0), act);
    check_csr("mstatus after mret", csr_mstatus, 64'h88);
  endtask

  task automatic test_timer_intr();
    exe_req_t    r;
    exe_result_t act;
    r                = make_instr(op_add, 64'h8000_0300, 64'd5, 64'd6, '0, 5'd4, 1'b1);
    i_mtie           = 1'b1;
    i_mtime_overflow = 1'b1;
    send_instr("timer interrupt", r);
    i_mtie           = 1'b0;
    i_mtime_overflow = 1'b0;
    get_result("timer interrupt", act);
    check_result("timer interrupt", model_trap(r, trap_vec, 1'b1), act);
    check_csr("mcause after interrupt", csr_mcause, 64'h8000_0000_0000_0007);
    check_csr("mepc after interrupt", csr_mepc, 64'h8000_0300);
  endtask

  task automatic test_backpressure();
    exe_req_t        r1;
    exe_req_t        r2;
    exe_result_t     held;
    exe_result_t     act;
    logic [xlen-1:0] wval;
    int              k;
    // old mepc has to stay in the record after the write edge
    wval = rand64() | 64'd1;
    r1   = make_instr(op_csrrw, 64'h400, wval, '0, xlen'(csr_mepc), 5'd5, 1'b1);
    r2   = make_instr(op_sub, 64'h404, rand64(), rand64(), '0, 5'd6, 1'b1);
    send_instr("stall first", r1);
    // second instruction waits on the bus the whole time
    i_dec_req   = 1'b1;
    i_dec_instr = r2;
    wait_exe_req("stall first");
    held = o_exe_result;
    check_result("stall first", model_exe(r1, 64'h8000_0300), held);
    for (k = 0; k < 6; k++) begin
      @(negedge clk);
      check_result("stall hold", held, o_exe_result);
      if (o_dec_ack || !o_exe_req) begin
        n_errors++;
        $display("stall hold: handshake moved while the result was not acknowledged");
      end
    end
    i_exe_ack = 1'b1;
    @(posedge clk);
    @(negedge clk);
    i_exe_ack = 1'b0;
    if (o_exe_req || !o_dec_ack) begin
      n_errors++;
      $display("stall release: stage did not return to idle after the acknowledge");
    end
    send_instr("stall second", r2);
    get_result("stall second", act);
    check_result("stall second", model_exe(r2, '0), act);
    check_csr("mepc after stall", csr_mepc, wval);
  endtask

  initial begin
    seed             = 99556;
    n_errors         = 0;
    n_checks         = 0;
    trap_vec         = 64'h8000_0100;
    rst              = 1'b1;
    i_dec_req        = 1'b0;
    i_dec_instr      = '0;
    i_mtie           = 1'b0;
    i_mtime_overflow = 1'b0;
    i_exe_ack        = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (o_exe_req || !o_dec_ack) begin
      n_errors++;
      $display("reset: stage is not idle after reset");
    end
    test_alu();
    test_branch_jump();
    test_csr();
    test_ecall_mret();
    test_timer_intr();
    test_backpressure();
    finish_run();
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
exe_pkg.sv
exe_unit.sv
exception_unit.sv
csr_file.sv
exe_stage.sv
exe_top.sv
tb_exe_top.sv
